// ==== flist.f ====
+incdir+sim
hdl/fifo_pkg.sv
hdl/sync_fifo.sv
hdl/chaos_lfsr.sv
hdl/fifo_csr.sv
hdl/fifo_top.sv
sim/tb_fifo_top.sv

// ==== hdl/chaos_lfsr.sv ====
//############################################################################
// free-running lfsr that requests a false full for back-pressure tests
// output is registered, so chaos_en low takes effect one edge later
//############################################################################
`timescale 1ns/1ps

module chaos_lfsr
  (
   input  logic                 clk,
   input  logic                 nreset,
   input  fifo_pkg::fifo_ctrl_t ctrl,
   output logic                 chaos_full
   );

   logic [fifo_pkg::lfsr_w-1:0] lfsr;
   logic                        feedback;
   logic                        hit;

   //#########################################################################
   // fibonacci lfsr, shifts left, new bit enters at 0
   //#########################################################################
   assign feedback = ^(lfsr & fifo_pkg::lfsr_taps);

   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
         lfsr <= fifo_pkg::lfsr_seed;
      else
         lfsr <= {lfsr[fifo_pkg::lfsr_w-2:0], feedback};   // steps every cycle

   // low nibble below threshold, thresh 0 never hits
   assign hit = (lfsr[3:0] < ctrl.chaos_thresh);

   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
         chaos_full <= 1'b0;
      else
         chaos_full <= ctrl.chaos_en & hit;

endmodule

// ==== hdl/fifo_csr.sv ====
//############################################################################
// apb slave for the fifo, no wait states, pready tied high
// unmapped address or write to STATUS -> pslverr, nothing changes
//############################################################################
`timescale 1ns/1ps

module fifo_csr
  (
   input  logic                 clk,
   input  logic                 nreset,
   input  fifo_pkg::apb_req_t   apb_req,
   output fifo_pkg::apb_rsp_t   apb_rsp,
   output fifo_pkg::fifo_ctrl_t ctrl,
   input  fifo_pkg::fifo_stat_t stat
   );

   logic                          access;      // second apb cycle
   logic                          wr_access;
   logic                          rd_access;
   logic                          hit_ctrl;
   logic                          hit_status;
   logic                          hit_drops;
   logic                          hit_under;
   logic                          mapped;
   logic                          wr_ctrl;
   logic [fifo_pkg::cnt_w-1:0]    drops_cnt;
   logic [fifo_pkg::cnt_w-1:0]    under_cnt;
   logic [fifo_pkg::apb_dw-1:0]   ctrl_rd;
   logic [fifo_pkg::apb_dw-1:0]   status_rd;
   logic [fifo_pkg::apb_dw-1:0]   rdata;

   // counter update, clear beats increment, holds at all ones
   function automatic logic [fifo_pkg::cnt_w-1:0] cnt_next
     (input logic [fifo_pkg::cnt_w-1:0] cnt,
      input logic                       inc,
      input logic                       clr);
      if (clr)
         return '0;
      else if (inc && (cnt != '1))
         return cnt + fifo_pkg::cnt_w'(1);
      else
         return cnt;
   endfunction

   //#########################################################################
   // decode
   //#########################################################################
   assign access    = apb_req.psel & apb_req.penable;
   assign wr_access = access & apb_req.pwrite;
   assign rd_access = access & ~apb_req.pwrite;

   assign hit_ctrl   = (apb_req.paddr == fifo_pkg::reg_ctrl_addr);
   assign hit_status = (apb_req.paddr == fifo_pkg::reg_status_addr);
   assign hit_drops  = (apb_req.paddr == fifo_pkg::reg_drops_addr);
   assign hit_under  = (apb_req.paddr == fifo_pkg::reg_under_addr);
   assign mapped     = hit_ctrl | hit_status | hit_drops | hit_under;

   assign wr_ctrl = wr_access & hit_ctrl;

   //#########################################################################
   // control register and event counters
   //#########################################################################
   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
      begin
         ctrl      <= '0;   // chaos off
         drops_cnt <= '0;
         under_cnt <= '0;
      end
      else
      begin
         if (wr_ctrl)
         begin
            ctrl.chaos_en     <= apb_req.pwdata[fifo_pkg::ctrl_en_bit];
            ctrl.chaos_thresh <= apb_req.pwdata[fifo_pkg::ctrl_thresh_lsb +: 4];
         end
         drops_cnt <= cnt_next(drops_cnt, stat.wr_drop, wr_access & hit_drops);
         under_cnt <= cnt_next(under_cnt, stat.rd_under, wr_access & hit_under);
      end

   //#########################################################################
   // readback
   //#########################################################################
   always_comb
   begin
      ctrl_rd                                        = '0;
      ctrl_rd[fifo_pkg::ctrl_en_bit]                 = ctrl.chaos_en;
      ctrl_rd[fifo_pkg::ctrl_thresh_lsb +: 4]        = ctrl.chaos_thresh;

      status_rd                                      = '0;
      status_rd[fifo_pkg::fifo_lw-1:0]               = stat.level;  // live pointers
      status_rd[fifo_pkg::stat_empty_bit]            = stat.empty;
      status_rd[fifo_pkg::stat_full_bit]             = stat.full;
   end

   always_comb
   begin
      rdata = '0;                 // unmapped reads return zero
      if (rd_access)
      begin
         if (hit_ctrl)
            rdata = ctrl_rd;
         else if (hit_status)
            rdata = status_rd;
         else if (hit_drops)
            rdata = {{(fifo_pkg::apb_dw-fifo_pkg::cnt_w){1'b0}}, drops_cnt};
         else if (hit_under)
            rdata = {{(fifo_pkg::apb_dw-fifo_pkg::cnt_w){1'b0}}, under_cnt};
      end
   end

   // response, always ready in the access cycle
   assign apb_rsp.prdata  = rdata;
   assign apb_rsp.pready  = 1'b1;
   assign apb_rsp.pslverr = access & (~mapped | (apb_req.pwrite & hit_status));

endmodule

// ==== hdl/fifo_pkg.sv ====
//############################################################################
// shared sizes, register map and structs for the fifo channel
// depth need not be a power of two, fifo_aw/fifo_lw follow from it
//############################################################################

package fifo_pkg;

   //#########################################################################
   // fifo geometry
   //#########################################################################
   localparam int fifo_dw    = 32;                   // data width
   localparam int fifo_depth = 6;                    // odd size on purpose, wrap not at 2^n
   localparam int fifo_aw    = $clog2(fifo_depth);   // index bits
   localparam int fifo_lw    = fifo_aw + 1;          // level needs one more bit

   // constants sized to the pointer and level fields
   localparam logic [fifo_aw-1:0] fifo_last      = fifo_aw'(fifo_depth - 1); // last index
   localparam logic [fifo_lw-1:0] fifo_level_max = fifo_lw'(fifo_depth);

   //#########################################################################
   // apb register map
   //#########################################################################
   localparam int apb_aw = 4;
   localparam int apb_dw = 32;

   localparam logic [apb_aw-1:0] reg_ctrl_addr   = 4'h0; // r/w
   localparam logic [apb_aw-1:0] reg_status_addr = 4'h4; // read only
   localparam logic [apb_aw-1:0] reg_drops_addr  = 4'h8; // clear on write
   localparam logic [apb_aw-1:0] reg_under_addr  = 4'hC; // clear on write

   // bit positions inside CTRL and STATUS
   localparam int ctrl_en_bit     = 0;
   localparam int ctrl_thresh_lsb = 4;
   localparam int stat_empty_bit  = 8;
   localparam int stat_full_bit   = 9;

   localparam int cnt_w = 8;           // event counters, saturate at 255

   //#########################################################################
   // chaos lfsr, x^16+x^14+x^13+x^11+1, maximal length
   //#########################################################################
   localparam int                lfsr_w    = 16;
   localparam logic [lfsr_w-1:0] lfsr_seed = 16'hACE1;  // must never be zero
   localparam logic [lfsr_w-1:0] lfsr_taps = 16'hB400;

   typedef struct packed {
      logic       chaos_en;      // allow false full
      logic [3:0] chaos_thresh;  // 0 = never, 15 = ~15/16 of cycles
   } fifo_ctrl_t;

   typedef struct packed {
      logic [fifo_lw-1:0] level;
      logic               full;      // real occupancy full, chaos not included
      logic               empty;
      logic               wr_drop;   // one cycle per refused write
      logic               rd_under;  // one cycle per read while empty
   } fifo_stat_t;

   typedef struct packed {
      logic              psel;
      logic              penable;
      logic              pwrite;
      logic [apb_aw-1:0] paddr;
      logic [apb_dw-1:0] pwdata;
   } apb_req_t;

   typedef struct packed {
      logic [apb_dw-1:0] prdata;
      logic              pready;
      logic              pslverr;
   } apb_rsp_t;

endpackage

// ==== hdl/fifo_top.sv ====
//############################################################################
// buffered stream channel, fifo plus chaos lfsr plus apb registers
// chaos is off after reset until CTRL is written
//############################################################################
`timescale 1ns/1ps

module fifo_top
  (
   input  logic                         clk,
   input  logic                         nreset,
   // stream in
   input  logic                         wr_en,
   input  logic [fifo_pkg::fifo_dw-1:0] wr_din,
   output logic                         wr_full,
   // stream out, fall-through
   input  logic                         rd_en,
   output logic [fifo_pkg::fifo_dw-1:0] rd_dout,
   output logic                         rd_empty,
   // register bus
   input  fifo_pkg::apb_req_t           apb_req,
   output fifo_pkg::apb_rsp_t           apb_rsp
   );

   fifo_pkg::fifo_ctrl_t ctrl;        // csr -> lfsr
   logic                 chaos_full;  // lfsr -> fifo
   fifo_pkg::fifo_stat_t stat;        // fifo -> csr

   //#########################################################################
   // datapath
   //#########################################################################
   sync_fifo u_fifo
     (
      .clk        (clk),
      .nreset     (nreset),
      .wr_en      (wr_en),
      .wr_din     (wr_din),
      .wr_full    (wr_full),
      .rd_en      (rd_en),
      .rd_dout    (rd_dout),
      .rd_empty   (rd_empty),
      .chaos_full (chaos_full),
      .stat       (stat)
      );

   // false full source
   chaos_lfsr u_chaos
     (
      .clk        (clk),
      .nreset     (nreset),
      .ctrl       (ctrl),
      .chaos_full (chaos_full)
      );

   //#########################################################################
   // registers
   //#########################################################################
   fifo_csr u_csr
     (
      .clk     (clk),
      .nreset  (nreset),
      .apb_req (apb_req),
      .apb_rsp (apb_rsp),
      .ctrl    (ctrl),
      .stat    (stat)
      );

endmodule

// ==== hdl/sync_fifo.sv ====
//############################################################################
// fall-through sync fifo, any depth, pointers carry a wrap bit
// rd_dout is valid only while rd_empty is low, storage has no reset
//############################################################################
`timescale 1ns/1ps

module sync_fifo
  (
   input  logic                         clk,
   input  logic                         nreset,
   // write side
   input  logic                         wr_en,
   input  logic [fifo_pkg::fifo_dw-1:0] wr_din,
   output logic                         wr_full,
   // read side
   input  logic                         rd_en,
   output logic [fifo_pkg::fifo_dw-1:0] rd_dout,
   output logic                         rd_empty,
   // false full request from the lfsr
   input  logic                         chaos_full,
   output fifo_pkg::fifo_stat_t         stat
   );

   // {wrap, index}
   logic [fifo_pkg::fifo_aw:0]   wr_ptr;
   logic [fifo_pkg::fifo_aw:0]   rd_ptr;
   logic                         ptr_full;     // occupancy full
   logic                         fifo_write;   // accepted write
   logic                         fifo_read;    // accepted pop
   logic [fifo_pkg::fifo_lw-1:0] wr_ext;
   logic [fifo_pkg::fifo_lw-1:0] rd_ext;
   logic [fifo_pkg::fifo_lw-1:0] level;
   logic                         wr_drop;
   logic                         rd_under;

   logic [fifo_pkg::fifo_dw-1:0] mem [fifo_pkg::fifo_depth];

   // step one pointer, wrap index at depth-1 and flip the wrap bit
   function automatic logic [fifo_pkg::fifo_aw:0] ptr_next
     (input logic [fifo_pkg::fifo_aw:0] ptr);
      if (ptr[fifo_pkg::fifo_aw-1:0] == fifo_pkg::fifo_last)
         return {~ptr[fifo_pkg::fifo_aw], {fifo_pkg::fifo_aw{1'b0}}};
      else
         return {ptr[fifo_pkg::fifo_aw], ptr[fifo_pkg::fifo_aw-1:0] + fifo_pkg::fifo_aw'(1)};
   endfunction

   //#########################################################################
   // flags
   //#########################################################################
   // same index, different lap -> full
   assign ptr_full = (wr_ptr[fifo_pkg::fifo_aw-1:0] == rd_ptr[fifo_pkg::fifo_aw-1:0]) &
                     (wr_ptr[fifo_pkg::fifo_aw] != rd_ptr[fifo_pkg::fifo_aw]);
   assign rd_empty = (wr_ptr == rd_ptr);
   assign wr_full  = ptr_full | chaos_full;   // chaos only ever adds back-pressure

   assign fifo_write = wr_en & ~wr_full;
   assign fifo_read  = rd_en & ~rd_empty;

   //#########################################################################
   // level
   //#########################################################################
   assign wr_ext = {1'b0, wr_ptr[fifo_pkg::fifo_aw-1:0]};
   assign rd_ext = {1'b0, rd_ptr[fifo_pkg::fifo_aw-1:0]};

   // writer one lap ahead -> add depth back in
   assign level = (wr_ptr[fifo_pkg::fifo_aw] == rd_ptr[fifo_pkg::fifo_aw]) ?
                  (wr_ext - rd_ext) :
                  (wr_ext + fifo_pkg::fifo_level_max - rd_ext);

   //#########################################################################
   // pointers and event pulses
   //#########################################################################
   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
      begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         wr_drop  <= 1'b0;
         rd_under <= 1'b0;
      end
      else
      begin
         if (fifo_write)
            wr_ptr <= ptr_next(wr_ptr);
         if (fifo_read)
            rd_ptr <= ptr_next(rd_ptr);
         wr_drop  <= wr_en & wr_full;    // refused write
         rd_under <= rd_en & rd_empty;   // pop on empty
      end

   // storage, write port only on accepted writes
   always_ff @(posedge clk)
      if (fifo_write)
         mem[wr_ptr[fifo_pkg::fifo_aw-1:0]] <= wr_din;

   assign rd_dout = mem[rd_ptr[fifo_pkg::fifo_aw-1:0]];   // oldest entry, fall-through

   // status to the register block
   assign stat.level    = level;
   assign stat.full     = ptr_full;
   assign stat.empty    = rd_empty;
   assign stat.wr_drop  = wr_drop;
   assign stat.rd_under = rd_under;

endmodule

// ==== run.sh ====
#!/bin/sh
# build with verilator, run, and decide pass or fail from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert --top-module tb_fifo_top -f flist.f \
   -o tb_fifo_top > build.log 2>&1 \
   || { cat build.log; echo "verilator build failed"; exit 1; }

./obj_dir/tb_fifo_top > sim.log 2>&1 ; cat sim.log

grep -q "TEST RESULT: FAIL" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log || { echo "simulation did not finish"; exit 1; }
echo "simulation completed without errors"
exit 0

// ==== sim/tb_apb_tasks.svh ====
//############################################################################
// apb master tasks and stimulus lfsr, included inside tb_fifo_top
// setup and access phases driven on rising edges, response sampled on falling
//############################################################################
`ifndef TB_APB_TASKS_SVH
`define TB_APB_TASKS_SVH

localparam int apb_timeout = 16;     // cycles allowed for pready

logic [15:0] stim_lfsr = 16'd4658;   // stimulus lfsr state

// one fibonacci step, x^16+x^15+x^13+x^4+1, new bit returned
function automatic logic rand_bit();
   logic fb;
   fb        = stim_lfsr[15] ^ stim_lfsr[14] ^ stim_lfsr[12] ^ stim_lfsr[3];
   stim_lfsr = {stim_lfsr[14:0], fb};
   return fb;
endfunction

function automatic logic [31:0] rand_word();
   logic [31:0] w;
   w = '0;
   for (int b = 0; b < 32; b++)
      w = {w[30:0], rand_bit()};   // one step per bit
   return w;
endfunction

// setup cycle then access cycle, no handshake yet
task automatic apb_setup(input logic wr, input logic [fifo_pkg::apb_aw-1:0] addr,
                         input logic [31:0] data);
   @(posedge clk);
   apb_req.psel    <= 1'b1;
   apb_req.penable <= 1'b0;
   apb_req.pwrite  <= wr;
   apb_req.paddr   <= addr;
   apb_req.pwdata  <= data;
   @(posedge clk);
   apb_req.penable <= 1'b1;
endtask

task automatic apb_write(input logic [fifo_pkg::apb_aw-1:0] addr, input logic [31:0] data,
                         output logic err);
   int waited;
   waited = 0;
   apb_setup(1'b1, addr, data);
   @(negedge clk);
   while (!apb_rsp.pready)
   begin
      if (waited == apb_timeout)
         report_fail("apb write timed out waiting for pready");
      waited++;
      @(negedge clk);
   end
   err = apb_rsp.pslverr;
   @(posedge clk);               // data lands on this edge
   apb_req <= '0;
endtask

task automatic apb_read(input logic [fifo_pkg::apb_aw-1:0] addr, output logic [31:0] data,
                        output logic err);
   int waited;
   waited = 0;
   apb_setup(1'b0, addr, '0);
   @(negedge clk);
   while (!apb_rsp.pready)
   begin
      if (waited == apb_timeout)
         report_fail("apb read timed out waiting for pready");
      waited++;
      @(negedge clk);
   end
   data = apb_rsp.prdata;        // mid access cycle
   err  = apb_rsp.pslverr;
   @(posedge clk);
   apb_req <= '0;
endtask

`endif

// ==== sim/tb_fifo_top.sv ====
//############################################################################
// testbench for fifo_top, a queue models the fifo, assertions check at negedge
// first failure stops the run, apb slave expected to answer without waits
//############################################################################
`timescale 1ns/1ps

module tb_fifo_top;

   logic                         clk;
   logic                         nreset;
   logic                         wr_en;
   logic [fifo_pkg::fifo_dw-1:0] wr_din;
   logic                         wr_full;
   logic                         rd_en;
   logic [fifo_pkg::fifo_dw-1:0] rd_dout;
   logic                         rd_empty;
   fifo_pkg::apb_req_t           apb_req;
   fifo_pkg::apb_rsp_t           apb_rsp;

   logic [fifo_pkg::fifo_dw-1:0] sb_q [$];    // expected contents, head = oldest
   logic [fifo_pkg::fifo_dw-1:0] sb_head;
   int                           sb_count;
   logic                         check_full;  // low while chaos can fake full

   fifo_top UUT
     (
      .clk      (clk),
      .nreset   (nreset),
      .wr_en    (wr_en),
      .wr_din   (wr_din),
      .wr_full  (wr_full),
      .rd_en    (rd_en),
      .rd_dout  (rd_dout),
      .rd_empty (rd_empty),
      .apb_req  (apb_req),
      .apb_rsp  (apb_rsp)
      );

   task automatic report_fail(input string msg);
      $display("%s", msg);
      $display("TEST RESULT: FAIL");
      $fatal(1);
   endtask

   `include "tb_apb_tasks.svh"

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp)
      else
         report_fail($sformatf("[ERROR] %s got 0x%h expected 0x%h", name, got, exp));
   endtask

   task automatic write_reg(input logic [fifo_pkg::apb_aw-1:0] addr, input logic [31:0] data,
                            input logic exp_err);
      logic err;
      apb_write(addr, data, err);
      check_value("pslverr", 32'(err), 32'(exp_err));
   endtask

   task automatic read_reg(input logic [fifo_pkg::apb_aw-1:0] addr, input logic [31:0] exp,
                           input logic exp_err);
      logic [31:0] data;
      logic        err;
      apb_read(addr, data, err);
      check_value("pslverr", 32'(err), 32'(exp_err));
      check_value($sformatf("prdata at 0x%h", addr), data, exp);
   endtask

   // STATUS as the register map defines it, level low, empty bit 8, full bit 9
   function automatic logic [31:0] status_word(input int count);
      logic [31:0] w;
      w    = 32'(count);
      w[8] = (count == 0);
      w[9] = (count == fifo_pkg::fifo_depth);
      return w;
   endfunction

   // fixed or random wr_en/rd_en for some cycles, then idle
   task automatic run_traffic(input int cycles, input logic random_mode,
                              input logic we, input logic re);
      int n;
      for (n = 0; n < cycles; n++)
      begin
         @(posedge clk);
         wr_en  <= random_mode ? rand_bit() : we;
         rd_en  <= random_mode ? rand_bit() : re;
         wr_din <= rand_word();
      end
      @(posedge clk);
      wr_en <= 1'b0;
      rd_en <= 1'b0;
      @(negedge clk);   // model settled
   endtask

   //#########################################################################
   // clock, watchdog, scoreboard
   //#########################################################################
   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;   // 100 ns
   end

   initial
   begin
      repeat (20000) @(posedge clk);
      report_fail("simulation ran past its cycle limit");
   end

   always @(posedge clk)
      if (nreset)
      begin
         if (wr_en && !wr_full)
            sb_q.push_back(wr_din);
         if (rd_en && !rd_empty)
            sb_q.delete(0);
         sb_count = sb_q.size();
         sb_head  = (sb_count != 0) ? sb_q[0] : '0;
      end

   dout_matches_head : assert property (@(negedge clk) disable iff (!nreset)
                                        !rd_empty |-> (rd_dout == sb_head))
      else report_fail($sformatf("[ERROR] rd_dout got 0x%h expected 0x%h",
                                 rd_dout, sb_head));

   empty_matches_model : assert property (@(negedge clk) disable iff (!nreset)
                                          rd_empty == (sb_count == 0))
      else report_fail($sformatf("[ERROR] rd_empty got 0x%h expected 0x%h",
                                 rd_empty, (sb_count == 0)));

   full_matches_model : assert property (@(negedge clk) disable iff (!nreset)
                                         check_full |->
                                         (wr_full == (sb_count == fifo_pkg::fifo_depth)))
      else report_fail($sformatf("[ERROR] wr_full got 0x%h expected 0x%h",
                                 wr_full, (sb_count == fifo_pkg::fifo_depth)));

   //#########################################################################
   // test sequence
   //#########################################################################
   initial
   begin
      int   i;
      logic seen;
      nreset     = 1'b0;
      wr_en      = 1'b0;
      wr_din     = '0;
      rd_en      = 1'b0;
      apb_req    = '0;
      sb_count   = 0;
      sb_head    = '0;
      check_full = 1'b1;
      repeat (16) @(posedge clk);
      nreset <= 1'b1;

      // reset state
      @(negedge clk);
      check_value("rd_empty", 32'(rd_empty), 32'h1);
      check_value("wr_full", 32'(wr_full), 32'h0);
      read_reg(fifo_pkg::reg_ctrl_addr, 32'h0, 1'b0);
      read_reg(fifo_pkg::reg_status_addr, 32'h100, 1'b0);   // level 0, empty
      read_reg(fifo_pkg::reg_drops_addr, 32'h0, 1'b0);
      read_reg(fifo_pkg::reg_under_addr, 32'h0, 1'b0);

      // fill, two refused writes, drain checks order
      run_traffic(8, 1'b0, 1'b1, 1'b0);
      read_reg(fifo_pkg::reg_status_addr, 32'h206, 1'b0);   // level 6, full
      read_reg(fifo_pkg::reg_drops_addr, 32'h2, 1'b0);
      run_traffic(6, 1'b0, 1'b0, 1'b1);

      // random traffic, pointers wrap many times past index 5
      for (i = 0; i < 8; i++)
      begin
         run_traffic(60, 1'b1, 1'b0, 1'b0);
         read_reg(fifo_pkg::reg_status_addr, status_word(sb_count), 1'b0);
      end

      // underflow count, then clear both counters
      run_traffic(sb_count, 1'b0, 1'b0, 1'b1);
      write_reg(fifo_pkg::reg_under_addr, 32'h0, 1'b0);
      run_traffic(3, 1'b0, 1'b0, 1'b1);
      read_reg(fifo_pkg::reg_under_addr, 32'h3, 1'b0);
      write_reg(fifo_pkg::reg_under_addr, 32'h0, 1'b0);
      read_reg(fifo_pkg::reg_under_addr, 32'h0, 1'b0);
      write_reg(fifo_pkg::reg_drops_addr, 32'h1234, 1'b0);
      read_reg(fifo_pkg::reg_drops_addr, 32'h0, 1'b0);

      // chaos on, threshold 15
      check_full = 1'b0;
      write_reg(fifo_pkg::reg_ctrl_addr, 32'hF1, 1'b0);
      read_reg(fifo_pkg::reg_ctrl_addr, 32'hF1, 1'b0);
      seen = 1'b0;
      for (i = 0; (i < 64) && !seen; i++)
      begin
         @(negedge clk);
         seen = wr_full && (sb_count < fifo_pkg::fifo_depth);
      end
      if (!seen)
         report_fail("chaos mode did not raise wr_full within 64 cycles");
      run_traffic(200, 1'b1, 1'b0, 1'b0);

      // threshold 0, then chaos off, no false full either way
      write_reg(fifo_pkg::reg_ctrl_addr, 32'h01, 1'b0);
      repeat (2) @(posedge clk);   // registered chaos_full drains
      check_full = 1'b1;
      run_traffic(100, 1'b1, 1'b0, 1'b0);
      write_reg(fifo_pkg::reg_ctrl_addr, 32'hF0, 1'b0);   // threshold 15, chaos_en low
      run_traffic(100, 1'b1, 1'b0, 1'b0);

      // readback and bus errors, only bits 0 and 7:4 of CTRL exist
      write_reg(fifo_pkg::reg_ctrl_addr, 32'hFFFF_FF5E, 1'b0);
      read_reg(fifo_pkg::reg_ctrl_addr, 32'h50, 1'b0);
      write_reg(fifo_pkg::reg_status_addr, 32'hFFFF_FFFF, 1'b1);
      write_reg(4'h2, 32'hFFFF_FFFF, 1'b1);
      read_reg(4'h2, 32'h0, 1'b1);
      read_reg(fifo_pkg::reg_ctrl_addr, 32'h50, 1'b0);     // unchanged
      read_reg(fifo_pkg::reg_status_addr, status_word(sb_count), 1'b0);

      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule
